// File: verilog/cam_params.svh
// image geometry and flow-control constants for the camera pipeline
// included by the pixel package and by every module that sizes addresses

`ifndef CAM_PARAMS_SVH
`define CAM_PARAMS_SVH

`define CAM_COLS    80                        // QQVGA / 2
`define CAM_ROWS    60
`define CAM_PXLS    (`CAM_COLS * `CAM_ROWS)   // 4800 pixels per frame
`define CAM_AW      13                        // 2^13 > 4800

// output slots owned by the consumer after reset
`define CAM_CREDITS 4

`endif

// File: verilog/pixel_pkg.sv
// pixel level types shared by capture, frame buffer and colour processing
// the camera bus bundle, the RGB444 word and the buffer write port

`default_nettype none

`include "cam_params.svh"

package pixel_pkg;

  typedef struct packed {
    logic       pclk;
    logic       vsync;
    logic       href;
    logic [7:0] data;
  } cam_bus_t;  // 11 bits

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb444_t;  // 12 bits

  typedef struct packed {
    logic                we;
    logic [`CAM_AW-1:0]  addr;
    rgb444_t             pixel;
  } fb_wr_t;  // 26 bits

endpackage

`default_nettype wire

// File: verilog/proc_pkg.sv
// processing control types for the scan and colour stages
// operation select, scan FSM states and the credit-controlled output stream
// the stream carries an RGB444 word from the pixel package

`default_nettype none

package proc_pkg;

  // colour operation applied to every pixel of a scan
  typedef enum logic [1:0] {
    OP_PASS   = 2'd0,
    OP_GRAY   = 2'd1,
    OP_INVERT = 2'd2,
    OP_THRESH = 2'd3
  } proc_op_e;

  // scan controller states
  typedef enum logic [1:0] {
    S_IDLE  = 2'd0,
    S_SCAN  = 2'd1,  // issuing reads while credits last
    S_DRAIN = 2'd2   // all reads issued, waiting for the last beat
  } scan_state_e;

  // one output beat, no ready: consumer must take every valid beat
  typedef struct packed {
    logic               valid;
    logic               last;   // final pixel of the frame
    pixel_pkg::rgb444_t pixel;
  } pxl_stream_t;  // 14 bits

endpackage

`default_nettype wire

// File: verilog/ov7670_capture.sv
// camera capture: pairs OV7670 bytes into RGB444 pixels and writes one frame
// pclk is sampled on clk, so edges come from the registered camera bus
// a frame is armed at a vsync fall only while the scan side is not busy

`timescale 1ns/100ps
`default_nettype none

`include "cam_params.svh"

module ov7670_capture (
  input  logic                clk,
  input  logic                rst_n,
  input  pixel_pkg::cam_bus_t cam,
  input  logic                busy,
  output pixel_pkg::fb_wr_t   fb_wr,
  output logic                frame_done
);

  import pixel_pkg::*;

  cam_bus_t           cam_q;
  logic               pclk_d;
  logic               vsync_d;
  logic               pclk_rise;
  logic               vsync_fall;
  logic               armed;      // frame in progress
  logic               byte_hi;    // next byte is the second of a pair
  logic               byte_take;
  logic               pair_done;
  logic               at_last;
  logic [3:0]         red_q;
  rgb444_t            pix_q;
  logic               wr_we;
  logic [`CAM_AW-1:0] wr_addr;

  assign pclk_rise  = cam_q.pclk & ~pclk_d;
  assign vsync_fall = ~cam_q.vsync & vsync_d;
  assign byte_take  = armed & cam_q.href & pclk_rise;
  assign pair_done  = byte_take & byte_hi;
  assign at_last    = (wr_addr == `CAM_AW'(`CAM_PXLS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cam_q      <= '0;
      pclk_d     <= 1'b0;
      vsync_d    <= 1'b0;
      armed      <= 1'b0;
      byte_hi    <= 1'b0;
      wr_we      <= 1'b0;
      wr_addr    <= '0;
      frame_done <= 1'b0;
    end else begin
      cam_q      <= cam;
      pclk_d     <= cam_q.pclk;
      vsync_d    <= cam_q.vsync;
      wr_we      <= pair_done;           // write one cycle after the second byte
      frame_done <= pair_done & at_last;

      if (!cam_q.href) begin
        byte_hi <= 1'b0;                 // every line starts on a first byte
      end else if (byte_take) begin
        byte_hi <= ~byte_hi;
      end

      if (vsync_fall && !busy && !armed) begin
        armed   <= 1'b1;
        wr_addr <= '0;
      end else if (wr_we) begin
        if (at_last) begin
          armed   <= 1'b0;               // frame complete, wait for next vsync
          wr_addr <= '0;
        end else begin
          wr_addr <= wr_addr + 1'b1;
        end
      end
    end
  end

  // byte payload, no reset needed
  always_ff @(posedge clk) begin
    if (byte_take && !byte_hi) begin
      red_q <= cam_q.data[3:0];
    end
    if (pair_done) begin
      pix_q <= '{red: red_q, green: cam_q.data[7:4], blue: cam_q.data[3:0]};
    end
  end

  assign fb_wr = '{we: wr_we, addr: wr_addr, pixel: pix_q};

endmodule

`default_nettype wire

// File: verilog/frame_buffer.sv
// frame buffer holding one captured image
// simple dual port: capture writes, processing reads with one cycle latency

`timescale 1ns/100ps
`default_nettype none

`include "cam_params.svh"

module frame_buffer (
  input  logic               clk,
  input  pixel_pkg::fb_wr_t  wr,
  input  logic [`CAM_AW-1:0] rd_addr,
  output pixel_pkg::rgb444_t rd_pixel
);

  import pixel_pkg::*;

  rgb444_t mem [`CAM_PXLS];

  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.addr] <= wr.pixel;
    end
  end

  // registered read, infers block RAM
  always_ff @(posedge clk) begin
    rd_pixel <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: verilog/pxl_counter.sv
// scan address counter for frame buffer reads
// cleared at scan start, steps on each issued read, flags the final pixel

`timescale 1ns/100ps
`default_nettype none

`include "cam_params.svh"

module pxl_counter (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               clear,
  input  logic               step,
  output logic [`CAM_AW-1:0] addr,
  output logic               last
);

  assign last = (addr == `CAM_AW'(`CAM_PXLS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr <= '0;
    end else if (clear) begin
      addr <= '0;
    end else if (step) begin
      if (last) begin
        addr <= '0;  // wrap after the final read
      end else begin
        addr <= addr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/scan_ctrl.sv
// scan FSM: reads the captured frame out under credit flow control
// starts the cycle after frame_done, issues one read per cycle while credits
// remain, then drains until the last beat has left the colour stage

`timescale 1ns/100ps
`default_nettype none

`include "cam_params.svh"

module scan_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               frame_done,
  input  proc_pkg::proc_op_e op,
  input  logic               credit_ret,
  input  logic               cnt_last,
  output logic               rd_en,
  output logic               cnt_clear,
  output logic               pix_valid,
  output logic               pix_last,
  output proc_pkg::proc_op_e op_hold,
  output logic               busy
);

  import proc_pkg::*;

  scan_state_e state;
  scan_state_e state_nxt;
  logic [2:0]  credits;   // 0 .. CAM_CREDITS
  logic        last_out;  // in step with pxl_out.last

  assign busy      = (state != S_IDLE);
  assign rd_en     = (state == S_SCAN) && (credits != 3'd0);
  assign cnt_clear = (state == S_IDLE) && frame_done;

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (frame_done) begin
          state_nxt = S_SCAN;
        end
      end
      S_SCAN: begin
        if (rd_en && cnt_last) begin
          state_nxt = S_DRAIN;
        end
      end
      S_DRAIN: begin
        if (last_out) begin
          state_nxt = S_IDLE;
        end
      end
      default: state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      credits   <= 3'(`CAM_CREDITS);
      op_hold   <= OP_PASS;
      pix_valid <= 1'b0;
      pix_last  <= 1'b0;
      last_out  <= 1'b0;
    end else begin
      state     <= state_nxt;
      credits   <= credits - {2'b00, rd_en} + {2'b00, credit_ret};
      pix_valid <= rd_en;              // buffer data valid next cycle
      pix_last  <= rd_en & cnt_last;
      last_out  <= pix_last;           // colour stage register
      if (cnt_clear) begin
        op_hold <= op;                 // held for the whole scan
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/color_proc.sv
// colour stage: applies the selected operation to each buffer pixel
// result is registered into the output stream, valid two cycles after rd_en

`timescale 1ns/100ps
`default_nettype none

module color_proc (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pix_valid,
  input  logic                  pix_last,
  input  proc_pkg::proc_op_e    op_hold,
  input  pixel_pkg::rgb444_t    pixel,
  output proc_pkg::pxl_stream_t pxl_out
);

  import pixel_pkg::*;
  import proc_pkg::*;

  logic [5:0] luma_sum;  // r + 2g + b, max 60
  logic [3:0] luma;
  rgb444_t    pix_nxt;
  rgb444_t    pix_q;
  logic       valid_q;
  logic       last_q;

  assign luma_sum = {2'b00, pixel.red} + {1'b0, pixel.green, 1'b0} + {2'b00, pixel.blue};
  assign luma     = luma_sum[5:2];  // divide by 4, truncated

  always_comb begin
    case (op_hold)
      OP_GRAY:   pix_nxt = '{red: luma, green: luma, blue: luma};
      OP_INVERT: pix_nxt = '{red:   4'd15 - pixel.red,
                            green: 4'd15 - pixel.green,
                            blue:  4'd15 - pixel.blue};
      OP_THRESH: pix_nxt = luma[3] ? 12'hfff : 12'h000;  // luma >= 8
      default:   pix_nxt = pixel;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= pix_valid;
      last_q  <= pix_valid & pix_last;
    end
  end

  always_ff @(posedge clk) begin
    if (pix_valid) begin
      pix_q <= pix_nxt;
    end
  end

  assign pxl_out = '{valid: valid_q, last: last_q, pixel: pix_q};

endmodule

`default_nettype wire

// File: verilog/top_ov7670.sv
// camera side data path: capture into a frame buffer, then a credit based
// scan through the colour stage to a downstream consumer
// credit_ret returns one output slot per pulse

`timescale 1ns/100ps
`default_nettype none

`include "cam_params.svh"

module top_ov7670 (
  input  logic                  clk,
  input  logic                  rst_n,
  input  pixel_pkg::cam_bus_t   cam,
  input  proc_pkg::proc_op_e    op,
  input  logic                  credit_ret,
  output proc_pkg::pxl_stream_t pxl_out,
  output logic                  busy
);

  import pixel_pkg::*;
  import proc_pkg::*;

  fb_wr_t             fb_wr;
  logic               frame_done;
  logic               rd_en;
  logic               cnt_clear;
  logic               cnt_last;
  logic [`CAM_AW-1:0] rd_addr;
  rgb444_t            rd_pixel;
  logic               pix_valid;
  logic               pix_last;
  proc_op_e           op_hold;

  ov7670_capture u_capture (
    .clk        (clk),
    .rst_n      (rst_n),
    .cam        (cam),
    .busy       (busy),
    .fb_wr      (fb_wr),
    .frame_done (frame_done)
  );

  // frame from the camera, read back by the scan
  frame_buffer u_cam_fb (
    .clk      (clk),
    .wr       (fb_wr),
    .rd_addr  (rd_addr),
    .rd_pixel (rd_pixel)
  );

  pxl_counter u_rd_cnt (
    .clk   (clk),
    .rst_n (rst_n),
    .clear (cnt_clear),
    .step  (rd_en),
    .addr  (rd_addr),
    .last  (cnt_last)
  );

  scan_ctrl u_scan_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .frame_done (frame_done),
    .op         (op),
    .credit_ret (credit_ret),
    .cnt_last   (cnt_last),
    .rd_en      (rd_en),
    .cnt_clear  (cnt_clear),
    .pix_valid  (pix_valid),
    .pix_last   (pix_last),
    .op_hold    (op_hold),
    .busy       (busy)
  );

  color_proc u_color_proc (
    .clk       (clk),
    .rst_n     (rst_n),
    .pix_valid (pix_valid),
    .pix_last  (pix_last),
    .op_hold   (op_hold),
    .pixel     (rd_pixel),
    .pxl_out   (pxl_out)
  );

endmodule

`default_nettype wire

// File: tb/top_ov7670_props.sv
// concurrent checks on the scan controller, bound into scan_ctrl
// credit bounds, reads only with a credit, idle right after reset

`timescale 1ns/100ps
`default_nettype none

`include "cam_params.svh"

module top_ov7670_props (
  input logic       clk,
  input logic       rst_n,
  input logic       rd_en,
  input logic       credit_ret,
  input logic [2:0] credits,
  input logic       busy
);

  logic [3:0] in_flight;  // reads not yet paid back by credit_ret

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + {3'b000, rd_en} - {3'b000, credit_ret};
    end
  end

  // consumer never returns more than it owns
  credit_bound: assert property (
    @(posedge clk) disable iff (!rst_n) credits <= 3'(`CAM_CREDITS)
  ) else $error("credit count above the consumer slots");

  read_needs_credit: assert property (
    @(posedge clk) disable iff (!rst_n) rd_en |-> (in_flight < 4'(`CAM_CREDITS))
  ) else $error("read issued with every consumer slot in flight");

  idle_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> !busy
  ) else $error("busy high right after reset");

endmodule

`default_nettype wire

// File: tb/tb_top_ov7670.sv
// directed testbench for the camera data path
// sends LFSR frames over the camera bus, returns output credits after
// random delays and checks every beat against a model of the colour operations

`timescale 1ns/100ps
`default_nettype none

`include "cam_params.svh"

module tb_top_ov7670;

  import pixel_pkg::*;
  import proc_pkg::*;

  logic        clk;
  logic        rst_n;
  cam_bus_t    cam;
  proc_op_e    op;
  logic        credit_ret;
  pxl_stream_t pxl_out;
  logic        busy;

  rgb444_t     frame_px [`CAM_PXLS];  // pixels the capture should hold
  rgb444_t     got_px[$];
  logic        got_last[$];
  logic        withhold;               // consumer keeps its credits
  int          beats_seen;
  int          credits_back;
  int          gap;                    // cycles until the next credit return
  logic [31:0] pix_lfsr;
  logic [31:0] crd_lfsr;
  int          errors;
  int          tests;
  int          failed;

  top_ov7670 u_top_ov7670 (
    .clk        (clk),
    .rst_n      (rst_n),
    .cam        (cam),
    .op         (op),
    .credit_ret (credit_ret),
    .pxl_out    (pxl_out),
    .busy       (busy)
  );

  bind scan_ctrl top_ov7670_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_en      (rd_en),
    .credit_ret (credit_ret),
    .credits    (credits),
    .busy       (busy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic rgb444_t next_pixel();
    logic [11:0] v;
    for (int i = 0; i < 12; i++) begin
      pix_lfsr = lfsr_step(pix_lfsr);
      v[i]     = pix_lfsr[0];
    end
    return v;
  endfunction

  function automatic int next_delay();
    int d;
    d = 0;
    for (int i = 0; i < 3; i++) begin
      crd_lfsr = lfsr_step(crd_lfsr);
      d        = (d << 1) | int'(crd_lfsr[0]);
    end
    return d;
  endfunction

  // reference model of the colour operations
  function automatic rgb444_t expect_pixel(input rgb444_t p, input proc_op_e o);
    int      y;
    rgb444_t e;
    y = (int'(p.red) + 2 * int'(p.green) + int'(p.blue)) / 4;
    case (o)
      OP_GRAY:   e = '{red: 4'(y), green: 4'(y), blue: 4'(y)};
      OP_INVERT: e = '{red:   4'(15 - int'(p.red)),
                      green: 4'(15 - int'(p.green)),
                      blue:  4'(15 - int'(p.blue))};
      OP_THRESH: e = (y >= 8) ? 12'hfff : 12'h000;
      default:   e = p;
    endcase
    return e;
  endfunction

  // output monitor, sampled away from the driving edge
  always @(negedge clk) begin
    if (rst_n === 1'b1 && pxl_out.valid === 1'b1) begin
      got_px.push_back(pxl_out.pixel);
      got_last.push_back(pxl_out.last);
      beats_seen++;
    end
  end

  // consumer: one credit back per beat, serialised with random gaps
  always @(posedge clk) begin
    credit_ret <= 1'b0;
    if (!withhold && beats_seen > credits_back) begin
      if (gap == 0) begin
        credit_ret <= 1'b1;
        credits_back++;
        gap = next_delay();
      end else begin
        gap--;
      end
    end
  end

  task automatic compare_pixel(input string name, input rgb444_t got, input rgb444_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    cam.pclk <= 1'b0;
    cam.href <= 1'b1;
    cam.data <= b;
    repeat (2) @(posedge clk);
    cam.pclk <= 1'b1;   // byte taken on this rise
    repeat (2) @(posedge clk);
  endtask

  // vsync pulse, then 60 lines of 160 bytes; keep stores the frame as reference
  task automatic send_frame(input logic keep);
    rgb444_t p;
    @(posedge clk);
    cam <= '{pclk: 1'b0, vsync: 1'b1, href: 1'b0, data: 8'h00};
    repeat (8) @(posedge clk);
    cam.vsync <= 1'b0;
    repeat (8) @(posedge clk);
    for (int r = 0; r < `CAM_ROWS; r++) begin
      for (int c = 0; c < `CAM_COLS; c++) begin
        p = next_pixel();
        if (keep) begin
          frame_px[r * `CAM_COLS + c] = p;
        end
        send_byte({~p.red, p.red});    // high nibble ignored
        send_byte({p.green, p.blue});
      end
      cam.href <= 1'b0;
      repeat (4) @(posedge clk);
    end
  endtask

  task automatic clear_capture();
    got_px.delete();
    got_last.delete();
  endtask

  task automatic wait_last();
    int n;
    n = 0;
    while (!(got_last.size() != 0 && got_last[got_last.size() - 1]) && n < 200000) begin
      @(negedge clk);
      n++;
    end
    if (n >= 200000) begin
      $display("Error at %0t: timed out waiting for the last beat", $time);
      errors++;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while ((busy || beats_seen != credits_back) && n < 1000) begin
      @(negedge clk);
      n++;
    end
    if (n >= 1000) begin
      $display("Error at %0t: scan did not go idle with all credits back", $time);
      errors++;
    end
    repeat (2) @(negedge clk);   // final credit reaches the counter
  endtask

  task automatic check_frame(input proc_op_e o);
    int n;
    compare_count("beat count", got_px.size(), `CAM_PXLS);
    n = (got_px.size() < `CAM_PXLS) ? got_px.size() : `CAM_PXLS;
    for (int i = 0; i < n; i++) begin
      compare_pixel($sformatf("pxl_out.pixel[%0d]", i), got_px[i],
                    expect_pixel(frame_px[i], o));
      compare_flag($sformatf("pxl_out.last[%0d]", i), got_last[i], i == `CAM_PXLS - 1);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %0d %s: pass", tests, name);
    end else begin
      failed++;
      $display("test %0d %s: fail, %0d errors", tests, name, errors - err_before);
    end
  endtask

  task automatic test_reset_idle();
    int e0;
    e0 = errors;
    repeat (100) begin
      @(negedge clk);
      compare_flag("busy", busy, 1'b0);
      compare_flag("pxl_out.valid", pxl_out.valid, 1'b0);
    end
    report_test("idle after reset", e0);
  endtask

  task automatic test_op_frame(input proc_op_e o);
    int e0;
    e0 = errors;
    clear_capture();
    @(posedge clk);
    op <= o;
    send_frame(1'b1);
    wait_last();
    wait_idle();
    check_frame(o);
    report_test($sformatf("frame %s", o.name()), e0);
  endtask

  task automatic test_withheld_credits();
    int e0;
    e0 = errors;
    clear_capture();
    @(posedge clk);
    op       <= OP_PASS;
    withhold <= 1'b1;
    send_frame(1'b1);
    repeat (200) @(posedge clk);
    @(negedge clk);
    compare_count("beats while credits withheld", got_px.size(), `CAM_CREDITS);
    @(posedge clk);
    withhold <= 1'b0;
    wait_last();
    wait_idle();
    check_frame(OP_PASS);
    report_test("credits withheld", e0);
  endtask

  task automatic test_frame_while_busy();
    int e0;
    e0 = errors;
    clear_capture();
    @(posedge clk);
    op       <= OP_INVERT;
    withhold <= 1'b1;          // keeps the scan busy through the next frame
    send_frame(1'b1);
    @(negedge clk);
    compare_flag("busy", busy, 1'b1);
    send_frame(1'b0);          // arrives while busy, must be dropped
    @(posedge clk);
    withhold <= 1'b0;
    wait_last();
    wait_idle();
    repeat (200) @(negedge clk);
    compare_flag("busy", busy, 1'b0);
    check_frame(OP_INVERT);
    report_test("frame while busy", e0);
  endtask

  initial begin
    rst_n        = 1'b0;
    cam          = '0;
    op           = OP_PASS;
    credit_ret   = 1'b0;
    withhold     = 1'b0;
    beats_seen   = 0;
    credits_back = 0;
    gap          = 0;
    pix_lfsr     = 32'hdada_3724;
    crd_lfsr     = 32'hdada_3724;
    errors       = 0;
    tests        = 0;
    failed       = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_idle();
    test_op_frame(OP_PASS);
    test_op_frame(OP_GRAY);
    test_op_frame(OP_INVERT);
    test_op_frame(OP_THRESH);
    test_withheld_credits();
    test_frame_while_busy();

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
verilog/pixel_pkg.sv
verilog/proc_pkg.sv
verilog/ov7670_capture.sv
verilog/frame_buffer.sv
verilog/pxl_counter.sv
verilog/scan_ctrl.sv
verilog/color_proc.sv
verilog/top_ov7670.sv
tb/top_ov7670_props.sv
tb/tb_top_ov7670.sv

// File: run.sh
#!/bin/sh
# build the camera pipeline testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tb_top_ov7670 -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_top_ov7670)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
